//--- list.f
rtl/cvt_pkg.sv
rtl/cvt_lane_if.sv
rtl/int_to_single_lane.sv
rtl/cvt_dispatch.sv
rtl/cvt_collect.sv
rtl/int_to_single_array.sv
tests/tb_clkgen.sv
tests/tb_int_to_single.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the converter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module tb_int_to_single -o sim_tb > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -q "RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "Simulation did not finish"; exit 1; }
exit 0

//--- tests/tb_int_to_single.sv
// Testbench for the multi-lane integer to single-precision converter
`timescale 1ns/1ps
`default_nettype none

module tb_int_to_single import cvt_pkg::*; ();

  localparam int NUM_LANES   = DEF_NUM_LANES;
  localparam int CLK_NS      = 4;
  // Directed, random stream and stall phase lengths
  localparam int N_DIRECTED  = 27;
  localparam int N_RANDOM    = 400;
  localparam int N_STALL     = 16;
  localparam int N_VEC       = N_DIRECTED + N_RANDOM + N_STALL;
  // Worst case of about 60 cycles per vector plus room for reset and the stall
  localparam int TIMEOUT_NS  = N_VEC * 60 * CLK_NS + 1000 * CLK_NS;

  // Exact small values, rounding ties and carries, then extremes and powers of two
  localparam int_word_t DIRECTED [N_DIRECTED] = '{
    32'sd0, 32'sd1, -32'sd1, 32'sd2, -32'sd2, 32'sd3, 32'sd7, 32'sd100, -32'sd100,
    32'sd12345, 32'sd16777215, -32'sd16777215,
    32'sd16777217, 32'sd16777219, 32'sd16777218, 32'sd33554435, 32'sd33554433,
    32'sh01FF_FFFF, 32'sh7FFF_FFC0, 32'sh7FFF_FF80, -32'sd16777217,
    32'sh7FFF_FFFF, 32'sh8000_0000, 32'sh4000_0000, 32'sh0001_0000, -32'sd65536,
    32'sh0080_0000
  };

  logic         clk;
  logic         rst;
  int_word_t    int_val;
  logic         int_cont;
  logic         int_ready;
  single_word_t single_val;
  logic         single_ready;
  logic         single_cont;

  // Sent values in order, results as drained
  int_word_t    sent_q [$];
  single_word_t got_q  [$];
  int_word_t    rand_vals [N_RANDOM + N_STALL];
  int           seed = 40025;
  int           n_sent;
  int           n_checked;
  logic         drain_hold;
  int           i;
  int           r;
  int           sh;
  single_word_t got;
  int_word_t    src;

  tb_clkgen #(
    .PERIOD_NS  (CLK_NS),
    .RST_CYCLES (3)
  ) u_clkgen (
    .clk (clk),
    .rst (rst)
  );

  int_to_single_array #(
    .NUM_LANES (NUM_LANES)
  ) u_dut (
    .clk          (clk),
    .rst          (rst),
    .int_val      (int_val),
    .int_cont     (int_cont),
    .int_ready    (int_ready),
    .single_val   (single_val),
    .single_ready (single_ready),
    .single_cont  (single_cont)
  );

  // Expected float word built from the IEEE-754 rules
  function automatic single_word_t to_single(input int_word_t v);
    logic        sign;
    logic [31:0] mag;
    logic [32:0] mant;
    logic [31:0] rem;
    logic [31:0] half;
    logic [7:0]  bexp;
    int          lead;
    int          shift;
    int          k;
    if (v == 0) begin
      return '0;
    end
    sign = v[31];
    mag  = sign ? 32'(-v) : 32'(v);
    // Position of the leading one is the unbiased exponent
    lead = 0;
    for (k = 0; k < 32; k++) begin
      if (mag[k]) begin
        lead = k;
      end
    end
    bexp = 8'(lead + 127);
    if (lead <= 23) begin
      mant = 33'(mag) << (23 - lead);
    end else begin
      shift = lead - 23;
      mant  = 33'(mag >> shift);
      rem   = mag & ((32'd1 << shift) - 32'd1);
      half  = 32'd1 << (shift - 1);
      // Above half rounds up, a tie goes to the even mantissa
      if (rem > half || (rem == half && mant[0])) begin
        mant = mant + 33'd1;
      end
      if (mant[24]) begin
        mant = mant >> 1;
        bexp = bexp + 8'd1;
      end
    end
    return {sign, bexp, mant[22:0]};
  endfunction

  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_single(input single_word_t got_w, input single_word_t exp_w,
                              input int_word_t src_w);
    if (got_w !== exp_w) begin
      $display("** Error at %0t: input %0d (0x%08h) gave 0x%08h, expected 0x%08h",
               $time, src_w, src_w, got_w, exp_w);
      abort_run();
    end
  endtask

  task automatic check_flag(input logic got_f, input logic exp_f, input string what);
    if (got_f !== exp_f) begin
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got_f, exp_f);
      abort_run();
    end
  endtask

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_int(input int_word_t v);
    while (!int_ready) @(negedge clk);
    int_val  = v;
    int_cont = 1'b1;
    sent_q.push_back(v);
    n_sent++;
    @(negedge clk);
    int_cont = 1'b0;
  endtask

  task automatic wait_drained();
    while (n_checked < n_sent) @(negedge clk);
  endtask

  // Drain with random gaps and take the result where it is held
  initial begin
    single_cont = 1'b0;
    forever begin
      @(negedge clk);
      single_cont = 1'b0;
      if (!rst && !drain_hold && single_ready && (($random(seed) & 3) != 0)) begin
        got_q.push_back(single_val);
        single_cont = 1'b1;
      end
    end
  end

  // Pairs every drained result with the oldest sent value
  initial begin
    forever begin
      wait (got_q.size() > 0);
      got = got_q.pop_front();
      if (sent_q.size() == 0) begin
        $display("A result came out with no input pending at %0t", $time);
        abort_run();
      end else begin
        src = sent_q.pop_front();
        check_single(got, to_single(src), src);
        n_checked++;
      end
    end
  end

  // Watchdog sized from the vector count
  initial begin
    #(TIMEOUT_NS);
    $display("The run timed out after %0d ns with %0d of %0d results checked",
             TIMEOUT_NS, n_checked, N_VEC);
    abort_run();
  end

  initial begin
    int_val    = '0;
    int_cont   = 1'b0;
    drain_hold = 1'b0;
    n_sent     = 0;
    n_checked  = 0;
    // Random words of random magnitude drawn before the drain uses the seed
    for (i = 0; i < N_RANDOM + N_STALL; i++) begin
      r            = $random(seed);
      sh           = $random(seed) & 31;
      rand_vals[i] = int_word_t'(r >>> sh);
    end

    // Handshake levels during reset and right after it
    @(negedge clk);
    while (rst) begin
      check_flag(int_ready, 1'b0, "int_ready in reset");
      check_flag(single_ready, 1'b0, "single_ready in reset");
      @(negedge clk);
    end
    check_flag(int_ready, 1'b0, "int_ready in first cycle after reset");
    check_flag(single_ready, 1'b0, "single_ready in first cycle after reset");
    @(negedge clk);
    check_flag(int_ready, 1'b1, "int_ready one cycle after reset");
    check_flag(single_ready, 1'b0, "single_ready before any input");

    for (i = 0; i < N_DIRECTED; i++) begin
      send_int(DIRECTED[i]);
    end
    wait_drained();

    // Several conversions in flight with random drain gaps
    for (i = 0; i < N_RANDOM; i++) begin
      send_int(rand_vals[i]);
    end
    wait_drained();

    // Fill every lane with the drain held off
    drain_hold = 1'b1;
    for (i = 0; i < NUM_LANES; i++) begin
      send_int(rand_vals[N_RANDOM + i]);
    end
    check_flag(int_ready, 1'b0, "int_ready with all lanes occupied");
    while (!single_ready) @(negedge clk);
    repeat (20) begin
      @(negedge clk);
      check_flag(int_ready, 1'b0, "int_ready while results are held");
    end
    drain_hold = 1'b0;
    for (i = NUM_LANES; i < N_STALL; i++) begin
      send_int(rand_vals[N_RANDOM + i]);
    end
    wait_drained();

    // No extra result is left over and every lane is free again
    drain_hold = 1'b1;
    repeat (4) @(negedge clk);
    check_flag(single_ready, 1'b0, "single_ready after the last result");
    check_flag(int_ready, 1'b1, "int_ready after the last result");
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/tb_clkgen.sv
// Testbench clock and reset source with a fixed period and reset length
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD_NS  = 4,
  parameter int RST_CYCLES = 3
) (
  output logic clk,
  output logic rst
);

  // Half period in ns
  localparam int HALF_NS = PERIOD_NS / 2;

  // Free-running clock, low at time zero
  initial begin
    clk = 1'b0;
    forever begin
      #(HALF_NS);
      clk = ~clk;
    end
  end

  // Released after the last reset edge, so the DUT samples RST_CYCLES of it
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

//--- rtl/int_to_single_array.sv
// Multi-lane signed integer to single-precision converter with in-order results
`timescale 1ns/1ps
`default_nettype none

module int_to_single_array import cvt_pkg::*; #(
  parameter int NUM_LANES = DEF_NUM_LANES
) (
  input  wire logic      clk,
  input  wire logic      rst,
  // Input handshake
  input  wire int_word_t int_val,
  input  wire logic      int_cont,
  output logic           int_ready,
  // Output handshake
  output single_word_t   single_val,
  output logic           single_ready,
  input  wire logic      single_cont
);

  // One handshake bundle per lane
  cvt_lane_if lane_bus [NUM_LANES] ();

  // Input side, round-robin over the lanes
  cvt_dispatch #(
    .NUM_LANES (NUM_LANES)
  ) u_dispatch (
    .clk       (clk),
    .rst       (rst),
    .int_val   (int_val),
    .int_cont  (int_cont),
    .int_ready (int_ready),
    .lanes     (lane_bus)
  );

  // Identical iterative converters
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    int_to_single_lane u_lane (
      .clk (clk),
      .rst (rst),
      .lif (lane_bus[g])
    );
  end

  // Output side, drained in the same order as dispatch
  cvt_collect #(
    .NUM_LANES (NUM_LANES)
  ) u_collect (
    .clk          (clk),
    .rst          (rst),
    .single_cont  (single_cont),
    .single_val   (single_val),
    .single_ready (single_ready),
    .lanes        (lane_bus)
  );

endmodule

`default_nettype wire

//--- rtl/cvt_collect.sv
// Round-robin collector draining lane results to the output in input order
`timescale 1ns/1ps
`default_nettype none

module cvt_collect import cvt_pkg::*; #(
  parameter int NUM_LANES = DEF_NUM_LANES
) (
  input  wire logic   clk,
  input  wire logic   rst,
  input  wire logic   single_cont,
  output single_word_t single_val,
  output logic        single_ready,
  cvt_lane_if.coll    lanes [NUM_LANES]
);

  // One bit minimum so a single lane still builds
  localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  // Lane whose result leaves next, same order as dispatch
  logic [PTR_W-1:0]     ptr;
  // Results and ready levels gathered from every lane
  single_word_t         lane_val   [NUM_LANES];
  logic [NUM_LANES-1:0] lane_ready;

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    assign lane_val[i]          = lanes[i].single_val;
    assign lane_ready[i]        = lanes[i].single_ready;
    // Strobe reaches the selected lane only
    assign lanes[i].single_cont = single_cont && (ptr == PTR_W'(i));
  end

  // Later lanes that finish early wait for their turn here
  assign single_val   = lane_val[ptr];
  assign single_ready = lane_ready[ptr];

  // Step on every completed transfer, wrap after the last lane
  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (single_cont && single_ready) begin
      if (ptr == PTR_W'(NUM_LANES - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  // Environment may only take a result that is offered
  a_cont_needs_ready: assert property (@(posedge clk) disable iff (rst)
    single_cont |-> single_ready)
    else $error("single_cont pulsed while single_ready low");

endmodule

`default_nettype wire

//--- rtl/cvt_dispatch.sv
// Round-robin dispatcher handing input integers to the converter lanes
`timescale 1ns/1ps
`default_nettype none

module cvt_dispatch import cvt_pkg::*; #(
  parameter int NUM_LANES = DEF_NUM_LANES
) (
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire int_word_t int_val,
  input  wire logic      int_cont,
  output logic           int_ready,
  cvt_lane_if.disp       lanes [NUM_LANES]
);

  // One bit minimum so a single lane still builds
  localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  // Lane whose turn it is to take the next integer
  logic [PTR_W-1:0]     ptr;
  // Ready levels gathered from every lane
  logic [NUM_LANES-1:0] lane_ready;

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    // Value goes to every lane, only the selected one sees the strobe
    assign lanes[i].int_val  = int_val;
    assign lanes[i].int_cont = int_cont && (ptr == PTR_W'(i));
    assign lane_ready[i]     = lanes[i].int_ready;
  end

  // Ready follows the lane under the pointer
  assign int_ready = lane_ready[ptr];

  // Step on every accepted transfer, wrap after the last lane
  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (int_cont && int_ready) begin
      if (ptr == PTR_W'(NUM_LANES - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  // Environment may only strobe while the selected lane is ready
  a_cont_needs_ready: assert property (@(posedge clk) disable iff (rst)
    int_cont |-> int_ready)
    else $error("int_cont pulsed while int_ready low");

endmodule

`default_nettype wire

//--- rtl/int_to_single_lane.sv
// Iterative signed integer to single-precision converter lane with round to nearest even
`timescale 1ns/1ps
`default_nettype none

module int_to_single_lane import cvt_pkg::*; (
  input wire logic clk,
  input wire logic rst,
  cvt_lane_if.lane lif
);

  // Exponent bias of the single format
  localparam exp_t EXP_BIAS = 8'd127;
  // Exponent of the top magnitude bit before any shift
  localparam exp_t TOP_EXP  = 8'd31;

  lane_state_e state;

  // Captured input word
  int_word_t   a;
  // Absolute value, unsigned so the most negative input is handled
  logic [31:0] mag;
  // Mantissa, remainder bits below it, exponent and sign
  mant_t       z_m;
  logic [7:0]  z_r;
  exp_t        z_e;
  logic        z_s;
  // Rounding bits taken once normalised
  logic        guard;
  logic        round_bit;
  logic        sticky;

  always_ff @(posedge clk) begin
    case (state)

      // Ready rises one cycle after arriving here
      IDLE_IN: begin
        lif.int_ready <= 1'b1;
        if (lif.int_ready && lif.int_cont) begin
          a             <= lif.int_val;
          lif.int_ready <= 1'b0;
          state         <= CHECK_SIGN;
        end
      end

      // Zero goes straight to pack as positive zero
      CHECK_SIGN: begin
        if (a == '0) begin
          z_s   <= 1'b0;
          z_m   <= '0;
          // Biased field then packs to zero
          z_e   <= 8'd0 - EXP_BIAS;
          state <= PACK;
        end else begin
          mag   <= a[31] ? 32'(-a) : 32'(a);
          z_s   <= a[31];
          state <= SPLIT;
        end
      end

      // Upper 24 bits as mantissa, low byte kept for rounding
      SPLIT: begin
        z_e   <= TOP_EXP;
        z_m   <= mag[31:8];
        z_r   <= mag[7:0];
        state <= NORMALISE;
      end

      // Shift until the hidden bit is set
      NORMALISE: begin
        if (!z_m[23]) begin
          z_e <= z_e - 1'b1;
          z_m <= {z_m[22:0], z_r[7]};
          z_r <= {z_r[6:0], 1'b0};
        end else begin
          guard     <= z_r[7];
          round_bit <= z_r[6];
          sticky    <= |z_r[5:0];
          state     <= ROUND;
        end
      end

      // Round up above half, or on a tie with an odd mantissa
      ROUND: begin
        if (guard && (round_bit || sticky || z_m[0])) begin
          z_m <= z_m + 1'b1;
          // All ones wraps to zero fraction, bump the exponent
          if (&z_m) begin
            z_e <= z_e + 1'b1;
          end
        end
        state <= PACK;
      end

      // Hidden bit dropped, exponent biased
      PACK: begin
        lif.single_val <= {z_s, 8'(z_e + EXP_BIAS), z_m[22:0]};
        state          <= HOLD_OUT;
      end

      // Hold until the collector takes it
      HOLD_OUT: begin
        lif.single_ready <= 1'b1;
        if (lif.single_ready && lif.single_cont) begin
          lif.single_ready <= 1'b0;
          state            <= IDLE_IN;
        end
      end

      default: begin
        state <= IDLE_IN;
      end

    endcase

    if (rst) begin
      state            <= IDLE_IN;
      lif.int_ready    <= 1'b0;
      lif.single_ready <= 1'b0;
      lif.single_val   <= '0;
    end
  end

  // A lane is either taking input or offering a result, never both
  a_ready_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(lif.int_ready && lif.single_ready))
    else $error("lane int_ready and single_ready both high");

  // Held result must not change until it is taken
  a_val_stable: assert property (@(posedge clk) disable iff (rst)
    lif.single_ready && !lif.single_cont |=> $stable(lif.single_val))
    else $error("lane single_val changed while held");

endmodule

`default_nettype wire

//--- rtl/cvt_lane_if.sv
// Handshake bundle between one converter lane, the dispatcher and the collector
`timescale 1ns/1ps
`default_nettype none

interface cvt_lane_if import cvt_pkg::*; ();

  // Input side, offered by the dispatcher
  int_word_t    int_val;
  logic         int_cont;
  // Raised by the lane while it can take a new integer
  logic         int_ready;

  // Output side, offered by the lane
  single_word_t single_val;
  // Raised by the lane while a result is held
  logic         single_ready;
  // Strobe from the collector taking the result
  logic         single_cont;

  // Dispatcher end
  modport disp (
    output int_val,
    output int_cont,
    input  int_ready
  );

  // Converter lane end
  modport lane (
    input  int_val,
    input  int_cont,
    output int_ready,
    output single_val,
    output single_ready,
    input  single_cont
  );

  // Collector end
  modport coll (
    input  single_val,
    input  single_ready,
    output single_cont
  );

endinterface

`default_nettype wire

//--- rtl/cvt_pkg.sv
// Shared types and defaults for the multi-lane integer to single-precision converter
`default_nettype none

package cvt_pkg;

  // Signed integer word taken at the input
  typedef logic signed [31:0] int_word_t;

  // Packed IEEE-754 single: sign, biased exponent, fraction
  typedef logic [31:0] single_word_t;

  // Working mantissa, hidden bit at the top
  typedef logic [23:0] mant_t;

  // Unbiased working exponent, two's complement in 8 bits
  typedef logic [7:0] exp_t;

  // Lane FSM states
  typedef enum logic [2:0] {
    // Waiting for an integer
    IDLE_IN    = 3'd0,
    // Zero check, sign and magnitude
    CHECK_SIGN = 3'd1,
    // Magnitude into mantissa and remainder
    SPLIT      = 3'd2,
    // One left shift per cycle
    NORMALISE  = 3'd3,
    // Round to nearest even
    ROUND      = 3'd4,
    // Assemble the float word
    PACK       = 3'd5,
    // Result held until drained
    HOLD_OUT   = 3'd6
  } lane_state_e;

  // Lane count used when the top level is not overridden
  localparam int DEF_NUM_LANES = 4;

endpackage

`default_nettype wire
